// File: wasm_mem_params.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sizing of the linear memory. WASM_MAX_PAGES sets the physical backing
// store, so keep it small for block RAM; grow never goes past it.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef WASM_MEM_PARAMS_SVH
`define WASM_MEM_PARAMS_SVH

// WebAssembly page is 64 KiB
`define WASM_PAGE_BYTES 65536

// Pages backed by physical storage
`define WASM_MAX_PAGES 2

// memory.grow result on failure (-1 as i32)
`define WASM_GROW_FAIL 32'hffff_ffff

`endif

// File: wasm_mem_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Types for the scalar linear memory. Data path is 64 bits wide, the
// access size is implied by the operation code.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package wasm_mem_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [63:0] data_t;
    typedef logic [7:0]  byte_t;
    typedef logic [31:0] pages_t;
    // Access length in bytes, 1 to 8
    typedef logic [3:0]  nbytes_t;

    typedef enum logic [3:0] {
        LOAD_I32,
        LOAD_I64,
        LOAD_I8_S,
        LOAD_I8_U,
        LOAD_I16_S,
        LOAD_I16_U,
        LOAD_I32_S,
        LOAD_I32_U,
        STORE_8,
        STORE_16,
        STORE_32,
        STORE_64
    } mem_op_e;

    typedef enum logic {
        TRAP_NONE,
        TRAP_OUT_OF_BOUNDS
    } trap_e;

    typedef struct packed {
        logic    valid;
        mem_op_e op;
        addr_t   addr;
        data_t   wdata;
    } mem_req_t;

    typedef struct packed {
        logic  rvalid;
        logic  error;
        data_t rdata;
    } mem_resp_t;

    typedef struct packed {
        logic   init_valid;
        pages_t init_pages;
        pages_t init_max_pages;
        logic   grow_valid;
        pages_t grow_pages;
    } mgmt_req_t;

    typedef struct packed {
        pages_t current_pages;
        pages_t grow_result;
        logic   grow_done;
    } mgmt_resp_t;

    // Checked access towards the byte store
    typedef struct packed {
        logic    rd;
        logic    wr;
        addr_t   addr;
        nbytes_t nbytes;
        data_t   wdata;
    } store_access_t;

    // Follows a load or a trapped access to the response stage
    typedef struct packed {
        logic    valid;
        logic    error;
        mem_op_e op;
    } load_tag_t;

endpackage

`default_nettype wire

// File: wasm_page_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Page count for memory.size and memory.grow. Init and grow must not
// be strobed in the same cycle; init wins if they are.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none
`include "wasm_mem_params.svh"

module wasm_page_ctrl (
    input  logic                     clk,
    input  logic                     rst_n,
    input  wasm_mem_pkg::mgmt_req_t  mgmt_req_i,
    output wasm_mem_pkg::mgmt_resp_t mgmt_resp_o,
    output wasm_mem_pkg::pages_t     current_pages_o
);
    import wasm_mem_pkg::*;

    localparam pages_t PHYS_PAGES = pages_t'(`WASM_MAX_PAGES);

    pages_t      cur_pages_q;
    pages_t      max_pages_q;
    pages_t      grow_result_q;
    logic        grow_done_q;
    logic [32:0] grow_sum;
    logic        grow_ok;

    // Extra bit so a huge request cannot wrap into range
    assign grow_sum = {1'b0, cur_pages_q} + {1'b0, mgmt_req_i.grow_pages};
    assign grow_ok  = (grow_sum <= {1'b0, max_pages_q}) && (grow_sum <= {1'b0, PHYS_PAGES});

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_pages_q   <= '0;
            max_pages_q   <= PHYS_PAGES;
            grow_result_q <= '0;
            grow_done_q   <= 1'b0;
        end else begin
            grow_done_q <= 1'b0;
            if (mgmt_req_i.init_valid) begin
                cur_pages_q <= (mgmt_req_i.init_pages > PHYS_PAGES) ?
                               PHYS_PAGES : mgmt_req_i.init_pages;
                // Zero means no declared maximum
                max_pages_q <= (mgmt_req_i.init_max_pages != '0) ?
                               mgmt_req_i.init_max_pages : PHYS_PAGES;
            end else if (mgmt_req_i.grow_valid) begin
                grow_done_q <= 1'b1;
                if (grow_ok) begin
                    grow_result_q <= cur_pages_q;
                    cur_pages_q   <= grow_sum[31:0];
                end else begin
                    grow_result_q <= `WASM_GROW_FAIL;
                end
            end
        end
    end

    assign mgmt_resp_o.current_pages = cur_pages_q;
    assign mgmt_resp_o.grow_result   = grow_result_q;
    assign mgmt_resp_o.grow_done     = grow_done_q;
    assign current_pages_o           = cur_pages_q;

endmodule

`default_nettype wire

// File: wasm_access_check.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Combinational request decode and bounds check. The limit is formed in
// 33 bits, which holds for page counts up to 65536.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none
`include "wasm_mem_params.svh"

module wasm_access_check (
    input  wasm_mem_pkg::mem_req_t      mem_req_i,
    input  wasm_mem_pkg::pages_t        current_pages_i,
    output wasm_mem_pkg::store_access_t access_o,
    output wasm_mem_pkg::load_tag_t     tag_o
);
    import wasm_mem_pkg::*;

    nbytes_t     nbytes;
    logic        is_load;
    logic [32:0] end_addr;
    logic [32:0] limit;
    logic        in_bounds;

    // Access size follows from the operation
    always_comb begin
        case (mem_req_i.op)
            LOAD_I8_S, LOAD_I8_U, STORE_8: begin
                nbytes = 4'd1;
            end
            LOAD_I16_S, LOAD_I16_U, STORE_16: begin
                nbytes = 4'd2;
            end
            LOAD_I64, STORE_64: begin
                nbytes = 4'd8;
            end
            default: begin
                nbytes = 4'd4;
            end
        endcase
    end

    assign is_load = mem_req_i.op inside {LOAD_I32, LOAD_I64, LOAD_I8_S, LOAD_I8_U,
                                          LOAD_I16_S, LOAD_I16_U, LOAD_I32_S, LOAD_I32_U};

    // Last byte must lie inside the declared pages
    assign end_addr  = {1'b0, mem_req_i.addr} + 33'(nbytes);
    assign limit     = 33'(current_pages_i) * 33'(`WASM_PAGE_BYTES);
    assign in_bounds = (end_addr <= limit);

    assign access_o.rd     = mem_req_i.valid && is_load && in_bounds;
    assign access_o.wr     = mem_req_i.valid && !is_load && in_bounds;
    assign access_o.addr   = mem_req_i.addr;
    assign access_o.nbytes = nbytes;
    assign access_o.wdata  = mem_req_i.wdata;

    // In-bounds stores need no response
    assign tag_o.valid = mem_req_i.valid && (is_load || !in_bounds);
    assign tag_o.error = mem_req_i.valid && !in_bounds;
    assign tag_o.op    = mem_req_i.op;

endmodule

`default_nettype wire

// File: wasm_byte_store.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Byte array backing WASM_MAX_PAGES pages. Writes are expected in bounds;
// reads return 8 bytes one cycle later, zero past the physical end.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none
`include "wasm_mem_params.svh"

module wasm_byte_store (
    input  logic                        clk,
    input  logic                        rst_n,
    input  wasm_mem_pkg::store_access_t access_i,
    output wasm_mem_pkg::data_t         rdata_o
);
    import wasm_mem_pkg::*;

    localparam int unsigned DEPTH = `WASM_MAX_PAGES * `WASM_PAGE_BYTES;

    byte_t mem [DEPTH];
    data_t rdata_q;

    // Power-up contents are zero
    initial begin
        for (int unsigned i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // Little-endian write of the low nbytes of wdata
    always @(posedge clk) begin
        if (access_i.wr) begin
            for (int i = 0; i < 8; i++) begin
                if (nbytes_t'(i) < access_i.nbytes) begin
                    mem[access_i.addr + addr_t'(i)] <= access_i.wdata[8*i +: 8];
                end
            end
        end
    end

    // Always fetch 8 bytes, the extend stage picks the ones it needs
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata_q <= '0;
        end else if (access_i.rd) begin
            for (int i = 0; i < 8; i++) begin
                if (access_i.addr + addr_t'(i) < addr_t'(DEPTH)) begin
                    rdata_q[8*i +: 8] <= mem[access_i.addr + addr_t'(i)];
                end else begin
                    rdata_q[8*i +: 8] <= '0;
                end
            end
        end
    end

    assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: wasm_load_extend.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Response stage. LOAD_I32 is zero-extended into the 64-bit result.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module wasm_load_extend (
    input  logic                    clk,
    input  logic                    rst_n,
    input  wasm_mem_pkg::load_tag_t tag_i,
    input  wasm_mem_pkg::data_t     rdata_i,
    output wasm_mem_pkg::mem_resp_t mem_resp_o,
    output wasm_mem_pkg::trap_e     trap_o
);
    import wasm_mem_pkg::*;

    load_tag_t tag_q;
    data_t     ext_data;

    // Tag lines up with the registered read data
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tag_q <= '0;
        end else begin
            tag_q <= tag_i;
        end
    end

    always_comb begin
        case (tag_q.op)
            LOAD_I8_S:  ext_data = {{56{rdata_i[7]}}, rdata_i[7:0]};
            LOAD_I8_U:  ext_data = {56'b0, rdata_i[7:0]};
            LOAD_I16_S: ext_data = {{48{rdata_i[15]}}, rdata_i[15:0]};
            LOAD_I16_U: ext_data = {48'b0, rdata_i[15:0]};
            LOAD_I32_S: ext_data = {{32{rdata_i[31]}}, rdata_i[31:0]};
            LOAD_I32,
            LOAD_I32_U: ext_data = {32'b0, rdata_i[31:0]};
            LOAD_I64:   ext_data = rdata_i;
            // Stores only reach here when trapped
            default:    ext_data = '0;
        endcase
    end

    assign mem_resp_o.rvalid = tag_q.valid && !tag_q.error;
    assign mem_resp_o.error  = tag_q.valid && tag_q.error;
    assign mem_resp_o.rdata  = ext_data;

    assign trap_o = (tag_q.valid && tag_q.error) ? TRAP_OUT_OF_BOUNDS : TRAP_NONE;

endmodule

`default_nettype wire

// File: wasm_memory_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Scalar WebAssembly linear memory. No back-pressure: one request per
// cycle, load response and trap arrive exactly one cycle later.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module wasm_memory_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  wasm_mem_pkg::mem_req_t   mem_req_i,
    output wasm_mem_pkg::mem_resp_t  mem_resp_o,
    input  wasm_mem_pkg::mgmt_req_t  mgmt_req_i,
    output wasm_mem_pkg::mgmt_resp_t mgmt_resp_o,
    output wasm_mem_pkg::trap_e      trap_o
);
    import wasm_mem_pkg::*;

    pages_t        current_pages;
    store_access_t access;
    load_tag_t     tag;
    data_t         rdata;

    wasm_page_ctrl u_page_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .mgmt_req_i      (mgmt_req_i),
        .mgmt_resp_o     (mgmt_resp_o),
        .current_pages_o (current_pages)
    );

    wasm_access_check u_access_check (
        .mem_req_i       (mem_req_i),
        .current_pages_i (current_pages),
        .access_o        (access),
        .tag_o           (tag)
    );

    wasm_byte_store u_byte_store (
        .clk      (clk),
        .rst_n    (rst_n),
        .access_i (access),
        .rdata_o  (rdata)
    );

    wasm_load_extend u_load_extend (
        .clk        (clk),
        .rst_n      (rst_n),
        .tag_i      (tag),
        .rdata_i    (rdata),
        .mem_resp_o (mem_resp_o),
        .trap_o     (trap_o)
    );

endmodule

`default_nettype wire

// File: wasm_memory_properties.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Protocol assertions, bound into every instance of the memory top.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none
`include "wasm_mem_params.svh"

module wasm_memory_properties (
    input wire logic                     clk,
    input wire logic                     rst_n,
    input wire wasm_mem_pkg::mem_req_t   mem_req_i,
    input wire wasm_mem_pkg::mem_resp_t  mem_resp_o,
    input wire wasm_mem_pkg::mgmt_req_t  mgmt_req_i,
    input wire wasm_mem_pkg::mgmt_resp_t mgmt_resp_o
);
    import wasm_mem_pkg::*;

    logic load_req;

    assign load_req = mem_req_i.valid && (mem_req_i.op < STORE_8);

    init_grow_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(mgmt_req_i.init_valid && mgmt_req_i.grow_valid))
        else $error("init and grow strobed in the same cycle");

    grow_done_follows: assert property (@(posedge clk) disable iff (!rst_n)
        mgmt_req_i.grow_valid |=> mgmt_resp_o.grow_done)
        else $error("grow_done missing one cycle after grow_valid");

    grow_done_only_after_grow: assert property (@(posedge clk) disable iff (!rst_n)
        mgmt_resp_o.grow_done |-> $past(mgmt_req_i.grow_valid))
        else $error("grow_done without a grow request");

    resp_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_resp_o.rvalid && mem_resp_o.error))
        else $error("rvalid and error high together");

    rvalid_after_load: assert property (@(posedge clk) disable iff (!rst_n)
        mem_resp_o.rvalid |-> $past(load_req))
        else $error("rvalid without a load in the previous cycle");

    pages_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        mgmt_resp_o.current_pages <= `WASM_MAX_PAGES)
        else $error("current_pages above the physical page count");

endmodule

bind wasm_memory_top wasm_memory_properties u_properties (
    .clk         (clk),
    .rst_n       (rst_n),
    .mem_req_i   (mem_req_i),
    .mem_resp_o  (mem_resp_o),
    .mgmt_req_i  (mgmt_req_i),
    .mgmt_resp_o (mgmt_resp_o)
);

`default_nettype wire

// File: wasm_memory_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench. Expected values come from a byte model and a page
// model; each response is checked in the cycle after its request.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none
`include "wasm_mem_params.svh"

module wasm_memory_tb;
    import wasm_mem_pkg::*;

    localparam int CYCLE_LIMIT = 3000;
    localparam int RESP_NONE   = 0;
    localparam int RESP_DATA   = 1;
    localparam int RESP_TRAP   = 2;
    localparam int PAGE        = `WASM_PAGE_BYTES;

    logic        clk;
    logic        rst_n;
    mem_req_t    mem_req;
    mem_resp_t   mem_resp;
    mgmt_req_t   mgmt_req;
    mgmt_resp_t  mgmt_resp;
    trap_e       trap;
    byte_t       ref_mem [int unsigned];
    pages_t      ref_pages;
    pages_t      ref_max;
    logic [31:0] lcg_state;
    int          pend_kind;
    data_t       pend_data;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cycles = 0;

    wasm_memory_top DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .mem_req_i   (mem_req),
        .mem_resp_o  (mem_resp),
        .mgmt_req_i  (mgmt_req),
        .mgmt_resp_o (mgmt_resp),
        .trap_o      (trap)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: tests still running after %0d cycles", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic void check_value(string name, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %h, expected %h", name, got, exp);
        end
    endfunction

    function automatic int op_bytes(mem_op_e op);
        case (op)
            LOAD_I8_S, LOAD_I8_U, STORE_8:    return 1;
            LOAD_I16_S, LOAD_I16_U, STORE_16: return 2;
            LOAD_I64, STORE_64:               return 8;
            default:                          return 4;
        endcase
    endfunction

    // Little-endian value of n model bytes, then extended by the load rule
    function automatic data_t expect_load(mem_op_e op, addr_t addr);
        int    n;
        data_t v;
        n = op_bytes(op);
        v = '0;
        for (int i = 0; i < n; i++) begin
            if (ref_mem.exists(addr + i)) begin
                v[8*i +: 8] = ref_mem[addr + i];
            end
        end
        if ((op inside {LOAD_I8_S, LOAD_I16_S, LOAD_I32_S}) && v[8*n-1]) begin
            v = v | ~((64'd1 << (8*n)) - 64'd1);
        end
        return v;
    endfunction

    // Drive one request cycle, then check the response to the previous one
    task automatic send(logic valid, mem_op_e op, addr_t addr, data_t wdata);
        int    kind;
        data_t exp;
        int    n;
        n    = op_bytes(op);
        kind = RESP_NONE;
        exp  = '0;
        if (valid && (longint'(addr) + n > longint'(ref_pages) * PAGE)) begin
            kind = RESP_TRAP;
        end else if (valid && (op < STORE_8)) begin
            kind = RESP_DATA;
            exp  = expect_load(op, addr);
        end else if (valid) begin
            for (int i = 0; i < n; i++) begin
                ref_mem[addr + i] = wdata[8*i +: 8];
            end
        end
        @(posedge clk);
        mem_req <= '{valid: valid, op: op, addr: addr, wdata: wdata};
        @(negedge clk);
        check_value("rvalid", mem_resp.rvalid, pend_kind == RESP_DATA);
        check_value("error", mem_resp.error, pend_kind == RESP_TRAP);
        check_value("trap_o", trap, (pend_kind == RESP_TRAP) ? TRAP_OUT_OF_BOUNDS : TRAP_NONE);
        if (pend_kind == RESP_DATA) begin
            check_value("rdata", mem_resp.rdata, pend_data);
        end
        pend_kind = kind;
        pend_data = exp;
    endtask

    task automatic idle();
        send(1'b0, LOAD_I32, '0, '0);
    endtask

    task automatic init_memory(pages_t pages, pages_t max_pages);
        @(posedge clk);
        mgmt_req.init_valid     <= 1'b1;
        mgmt_req.init_pages     <= pages;
        mgmt_req.init_max_pages <= max_pages;
        @(posedge clk);
        mgmt_req.init_valid <= 1'b0;
        ref_pages = (pages > `WASM_MAX_PAGES) ? `WASM_MAX_PAGES : pages;
        ref_max   = (max_pages != 0) ? max_pages : `WASM_MAX_PAGES;
        @(negedge clk);
        check_value("current_pages", mgmt_resp.current_pages, ref_pages);
    endtask

    task automatic grow_memory(pages_t delta);
        logic [32:0] sum;
        pages_t      exp_result;
        sum        = {1'b0, ref_pages} + {1'b0, delta};
        exp_result = `WASM_GROW_FAIL;
        if (sum <= {1'b0, ref_max} && sum <= `WASM_MAX_PAGES) begin
            exp_result = ref_pages;
            ref_pages  = sum[31:0];
        end
        @(posedge clk);
        mgmt_req.grow_valid <= 1'b1;
        mgmt_req.grow_pages <= delta;
        @(posedge clk);
        mgmt_req.grow_valid <= 1'b0;
        @(negedge clk);
        check_value("grow_done", mgmt_resp.grow_done, 1);
        check_value("grow_result", mgmt_resp.grow_result, exp_result);
        check_value("current_pages", mgmt_resp.current_pages, ref_pages);
    endtask

    function automatic void report(string name, int start);
        tests_run++;
        if (errors == start) begin
            $display("%s: PASS", name);
        end else begin
            tests_failed++;
            $display("%s: FAIL with %0d errors", name, errors - start);
        end
    endfunction

    task automatic reset_traps();
        int start;
        start = errors;
        check_value("current_pages", mgmt_resp.current_pages, 0);
        check_value("grow_done", mgmt_resp.grow_done, 0);
        send(1'b1, LOAD_I32, 32'h0, '0);
        send(1'b1, LOAD_I8_U, 32'h100, '0);
        send(1'b1, STORE_64, 32'h0, 64'h1);
        idle();
        report("reset", start);
    endtask

    task automatic store_load_order();
        int      start;
        addr_t   addr;
        mem_op_e wr_op [4];
        start = errors;
        wr_op = '{STORE_8, STORE_16, STORE_32, STORE_64};
        init_memory(1, 0);
        for (int round = 0; round < 2; round++) begin
            foreach (wr_op[i]) begin
                addr = lcg_next() % (PAGE - 8);
                send(1'b1, wr_op[i], addr, {lcg_next(), lcg_next()});
                idle();
                send(1'b1, LOAD_I64, addr, '0);
                send(1'b1, LOAD_I32, addr, '0);
            end
        end
        idle();
        report("store_load", start);
    endtask

    task automatic narrow_extend();
        int      start;
        data_t   pattern [2];
        mem_op_e ld_op [7];
        start   = errors;
        // Top bits of byte, half and word all set, then all clear
        pattern = '{64'hfedc_ba98_8765_c3a1, 64'h0123_4567_3456_7a5c};
        ld_op   = '{LOAD_I8_S, LOAD_I8_U, LOAD_I16_S, LOAD_I16_U,
                    LOAD_I32_S, LOAD_I32_U, LOAD_I32};
        foreach (pattern[p]) begin
            send(1'b1, STORE_64, 32'h301 + 16*p, pattern[p]);
            foreach (ld_op[i]) begin
                send(1'b1, ld_op[i], 32'h301 + 16*p, '0);
            end
        end
        idle();
        report("extend", start);
    endtask

    task automatic bounds_trap();
        int start;
        start = errors;
        init_memory(1, 0);
        send(1'b1, STORE_64, PAGE - 8, {lcg_next(), lcg_next()});
        send(1'b1, LOAD_I64, PAGE - 8, '0);
        send(1'b1, LOAD_I64, PAGE - 7, '0);
        send(1'b1, STORE_32, PAGE - 3, 64'h5a5a_5a5a);
        send(1'b1, LOAD_I32, PAGE - 4, '0);
        send(1'b1, STORE_16, PAGE - 1, 64'hc3c3);
        send(1'b1, STORE_8, PAGE - 1, 64'h96);
        send(1'b1, LOAD_I64, PAGE - 8, '0);
        send(1'b1, LOAD_I8_U, PAGE, '0);
        idle();
        report("bounds", start);
    endtask

    task automatic grow_limits();
        int start;
        start = errors;
        init_memory(1, 0);
        grow_memory(1);
        send(1'b1, STORE_64, PAGE + 16, {lcg_next(), lcg_next()});
        send(1'b1, LOAD_I64, PAGE + 16, '0);
        idle();
        grow_memory(1);
        grow_memory(32'hffff_ffff);
        // Declared maximum above the physical pages
        init_memory(5, 8);
        grow_memory(1);
        init_memory(1, 1);
        grow_memory(1);
        grow_memory(0);
        send(1'b1, LOAD_I8_U, PAGE + 16, '0);
        idle();
        report("grow", start);
    endtask

    task automatic back_to_back();
        int    start;
        addr_t addr;
        start = errors;
        init_memory(2, 0);
        for (int i = 0; i < 6; i++) begin
            addr = lcg_next() % (2 * PAGE - 8);
            send(1'b1, STORE_64, addr, {lcg_next(), lcg_next()});
            send(1'b1, (i % 2) ? LOAD_I16_S : LOAD_I64, addr, '0);
        end
        for (int i = 0; i < 8; i++) begin
            send(1'b1, LOAD_I32_S, addr - 4 * i, '0);
        end
        idle();
        report("streams", start);
    endtask

    initial begin
        rst_n     = 1'b0;
        mem_req   = '0;
        mgmt_req  = '0;
        lcg_state = 32'hc92d_e2f5;
        ref_pages = '0;
        ref_max   = `WASM_MAX_PAGES;
        pend_kind = RESP_NONE;
        pend_data = '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        reset_traps();
        store_load_order();
        narrow_extend();
        bounds_trap();
        grow_limits();
        back_to_back();
        idle();
        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+.
wasm_mem_pkg.sv
wasm_page_ctrl.sv
wasm_access_check.sv
wasm_byte_store.sv
wasm_load_extend.sv
wasm_memory_top.sv
wasm_memory_properties.sv
wasm_memory_tb.sv

// File: Bender.yml
package:
  name: wasm_memory

export_include_dirs:
  - .

sources:
  - files:
      - wasm_mem_pkg.sv
      - wasm_page_ctrl.sv
      - wasm_access_check.sv
      - wasm_byte_store.sv
      - wasm_load_extend.sv
      - wasm_memory_top.sv
  - target: test
    files:
      - wasm_memory_properties.sv
      - wasm_memory_tb.sv
